/* hdl/pix_settings.svh */
`ifndef PIX_SETTINGS_SVH
`define PIX_SETTINGS_SVH

// pixel and frame geometry
`define PIX_W      8
`define FRAME_W    16
`define FRAME_H    16
`define BLK        8
`define FRAME_PIX  256
`define FRAME_AW   8

`define LUT_DEPTH  256
`define OUT_DEPTH  4           // output fifo entries

// apb register map
`define REG_CMD    4'h0
`define REG_PARAM  4'h4
`define REG_LUT    4'h8
`define REG_STATUS 4'hC
`define CMD_TAG    8'hA0

`endif

/* hdl/pix_bus_pkg.sv */
`default_nettype none

`include "pix_settings.svh"

package pix_bus_pkg;

    // apb without pready so every transfer is zero wait
    typedef struct packed {
        logic        sel;
        logic        enable;
        logic        write;
        logic [3:0]  addr;
        logic [31:0] wdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        slverr;
    } apb_rsp_t;

    typedef struct packed {
        logic              valid;
        logic [`PIX_W-1:0] data;
    } pix_in_t;

    typedef struct packed {
        logic              valid;
        logic [`PIX_W-1:0] data;
        logic              last;   // pixel 255 of a run
    } pix_out_t;

endpackage

`default_nettype wire

/* hdl/pix_task_pkg.sv */
`default_nettype none

`include "pix_settings.svh"

package pix_task_pkg;

    typedef enum logic [3:0] {
        TASK_COPY   = 4'd0,
        TASK_INVERT = 4'd1,
        TASK_THRESH = 4'd2,
        TASK_LUT    = 4'd3
    } task_e;

    // 0xA0n0 style command word
    typedef struct packed {
        logic [7:0] tag;
        logic [3:0] task_num;
        logic [3:0] spare;
    } cmd_fields_t;

    typedef union packed {
        logic [15:0] raw;
        cmd_fields_t f;
    } cmd_word_u;

    typedef struct packed {
        task_e             op;
        logic [`PIX_W-1:0] thresh;
    } task_cfg_t;

    typedef struct packed {
        logic              valid;
        logic [7:0]        addr;
        logic [`PIX_W-1:0] data;
    } lut_wr_t;

endpackage

`default_nettype wire

/* hdl/apb_cmd_decode.sv */
`default_nettype none

`include "pix_settings.svh"

module apb_cmd_decode (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  pix_bus_pkg::apb_req_t  apb_i,
    output pix_bus_pkg::apb_rsp_t  apb_o,
    input  logic                   frame_loaded_i,
    input  logic                   frame_done_i,
    output logic                   start_o,
    output pix_task_pkg::task_cfg_t cfg_o,
    output pix_task_pkg::lut_wr_t  lut_wr_o
);

    logic                   access;
    logic                   wr_acc;
    logic                   cmd_wr;
    logic                   cmd_bad;
    logic                   busy_q;
    logic                   done_q;
    logic [`PIX_W-1:0]      param_q;
    pix_task_pkg::cmd_word_u cmd;

    assign access = apb_i.sel & apb_i.enable;
    assign wr_acc = access & apb_i.write;
    assign cmd_wr = wr_acc && (apb_i.addr == `REG_CMD);

    assign cmd.raw = apb_i.wdata[15:0];

    ////////////////////////////////////////////////////////////
    // command check
    ////////////////////////////////////////////////////////////

    assign cmd_bad = (cmd.f.tag != `CMD_TAG) ||
                     (cmd.f.task_num > 4'(pix_task_pkg::TASK_LUT)) ||
                     busy_q || !frame_loaded_i;

    assign start_o      = cmd_wr & ~cmd_bad;
    assign apb_o.slverr = cmd_wr & cmd_bad;

    // status is the only readable word
    always_comb begin
        apb_o.rdata = '0;
        if (access && !apb_i.write && apb_i.addr == `REG_STATUS) begin
            apb_o.rdata[0] = frame_loaded_i;
            apb_o.rdata[1] = busy_q;
            apb_o.rdata[2] = done_q;
        end
    end

    // table writes go straight through
    always_comb begin
        lut_wr_o.valid = wr_acc && (apb_i.addr == `REG_LUT);
        lut_wr_o.addr  = apb_i.wdata[15:8];
        lut_wr_o.data  = apb_i.wdata[`PIX_W-1:0];
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_q       <= 1'b0;
            done_q       <= 1'b0;
            param_q      <= '0;
            cfg_o.op     <= pix_task_pkg::TASK_COPY;
            cfg_o.thresh <= '0;
        end else begin
            if (wr_acc && apb_i.addr == `REG_PARAM) begin
                param_q <= apb_i.wdata[`PIX_W-1:0];
            end
            if (start_o) begin
                busy_q       <= 1'b1;
                done_q       <= 1'b0;
                cfg_o.op     <= pix_task_pkg::task_e'(cmd.f.task_num);
                cfg_o.thresh <= param_q;  // level latched per run
            end else if (frame_done_i) begin
                busy_q <= 1'b0;
                done_q <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/block_placer.sv */
`default_nettype none

`include "pix_settings.svh"

module block_placer (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  pix_bus_pkg::pix_in_t   pix_i,
    output logic                   in_ready_o,
    output logic                   wr_en_o,
    output logic [`FRAME_AW-1:0]   wr_addr_o,
    output logic [`PIX_W-1:0]      wr_data_o,
    output logic                   frame_loaded_o
);

    localparam int BW = $clog2(`BLK);
    localparam int CW = $clog2(`FRAME_W / `BLK);
    localparam int RW = $clog2(`FRAME_H / `BLK);

    logic [BW-1:0] col_q;    // column in block
    logic [BW-1:0] row_q;    // row in block
    logic [CW-1:0] bcol_q;
    logic [RW-1:0] brow_q;
    logic          all_in_q;
    logic          accept;
    logic          last_pix;

    assign in_ready_o = ~all_in_q;
    assign accept     = pix_i.valid & in_ready_o;
    assign last_pix   = &{brow_q, bcol_q, row_q, col_q};

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            col_q          <= '0;
            row_q          <= '0;
            bcol_q         <= '0;
            brow_q         <= '0;
            all_in_q       <= 1'b0;
            wr_en_o        <= 1'b0;
            frame_loaded_o <= 1'b0;
        end else begin
            wr_en_o <= accept;
            if (accept) begin
                col_q <= col_q + 1'b1;
                if (&col_q) begin
                    row_q <= row_q + 1'b1;
                    if (&row_q) begin
                        bcol_q <= bcol_q + 1'b1;
                        if (&bcol_q) brow_q <= brow_q + 1'b1;
                    end
                end
                if (last_pix) all_in_q <= 1'b1;
            end
            if (all_in_q) frame_loaded_o <= 1'b1;  // last write lands this edge
        end
    end

    // (brow*8 + row)*16 + bcol*8 + col
    always_ff @(posedge clk_i) begin
        if (accept) begin
            wr_addr_o <= {brow_q, row_q, bcol_q, col_q};
            wr_data_o <= pix_i.data;
        end
    end

endmodule

`default_nettype wire

/* hdl/frame_ram.sv */
`default_nettype none

`include "pix_settings.svh"

module frame_ram (
    input  logic                 clk_i,
    input  logic                 wr_en_i,
    input  logic [`FRAME_AW-1:0] wr_addr_i,
    input  logic [`PIX_W-1:0]    wr_data_i,
    input  logic [`FRAME_AW-1:0] rd_addr_i,
    output logic [`PIX_W-1:0]    rd_data_o
);

    logic [`PIX_W-1:0] mem [`FRAME_PIX];

    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
        rd_data_o <= mem[rd_addr_i];   // one cycle read
    end

endmodule

`default_nettype wire

/* hdl/task_execute.sv */
`default_nettype none

`include "pix_settings.svh"

module task_execute (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    start_i,
    input  pix_task_pkg::task_cfg_t cfg_i,
    input  pix_task_pkg::lut_wr_t   lut_wr_i,
    output logic [`FRAME_AW-1:0]    rd_addr_o,
    input  logic [`PIX_W-1:0]       rd_data_i,
    input  logic [2:0]              free_slots_i,
    output logic                    beat_valid_o,
    output logic [`PIX_W-1:0]       beat_data_o
);

    localparam logic [`FRAME_AW-1:0] LAST_IDX = `FRAME_AW'(`FRAME_PIX - 1);

    logic [`PIX_W-1:0]    lut_mem [`LUT_DEPTH];
    logic [`FRAME_AW-1:0] rd_cnt_q;
    logic                 active_q;
    logic                 rd_pend_q;   // data at the ram output
    logic [2:0]           in_flight_q;
    logic                 issue;
    logic [`PIX_W-1:0]    task_pix;

    ////////////////////////////////////////////////////////////
    // raster read issue
    ////////////////////////////////////////////////////////////

    // first read goes out in the start cycle
    assign issue     = (active_q | start_i) && (in_flight_q < free_slots_i);
    assign rd_addr_o = rd_cnt_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rd_cnt_q    <= '0;
            active_q    <= 1'b0;
            rd_pend_q   <= 1'b0;
            in_flight_q <= '0;
        end else begin
            if (start_i) active_q <= 1'b1;
            if (issue) begin
                rd_cnt_q <= rd_cnt_q + 1'b1;  // wraps to 0 after the frame
                if (rd_cnt_q == LAST_IDX) active_q <= 1'b0;
            end
            rd_pend_q   <= issue;
            in_flight_q <= in_flight_q + 3'(issue) - 3'(beat_valid_o);
        end
    end

    ////////////////////////////////////////////////////////////
    // point task stage
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (lut_wr_i.valid) begin
            lut_mem[lut_wr_i.addr] <= lut_wr_i.data;
        end
    end

    always_comb begin
        case (cfg_i.op)
            pix_task_pkg::TASK_INVERT: task_pix = ~rd_data_i;  // 255 - p
            pix_task_pkg::TASK_THRESH:
                task_pix = (rd_data_i >= cfg_i.thresh) ? '1 : '0;
            pix_task_pkg::TASK_LUT:    task_pix = lut_mem[rd_data_i];
            default:                   task_pix = rd_data_i;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            beat_valid_o <= 1'b0;
        end else begin
            beat_valid_o <= rd_pend_q;
        end
    end

    always_ff @(posedge clk_i) begin
        beat_data_o <= task_pix;
    end

endmodule

`default_nettype wire

/* hdl/result_stream.sv */
`default_nettype none

`include "pix_settings.svh"

module result_stream (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic                            beat_valid_i,
    input  logic [`PIX_W-1:0]               beat_data_i,
    output logic [$clog2(`OUT_DEPTH):0]     free_slots_o,
    output pix_bus_pkg::pix_out_t           pix_o,
    input  logic                            out_ready_i,
    output logic                            frame_done_o
);

    localparam int PW = $clog2(`OUT_DEPTH);
    localparam logic [`FRAME_AW-1:0] LAST_IDX = `FRAME_AW'(`FRAME_PIX - 1);

    logic [`PIX_W-1:0]    fifo_mem [`OUT_DEPTH];
    logic [PW-1:0]        wr_ptr_q;
    logic [PW-1:0]        rd_ptr_q;
    logic [PW:0]          count_q;
    logic [`FRAME_AW-1:0] out_cnt_q;   // pixels sent this run
    logic                 out_valid;
    logic                 pop;

    assign out_valid    = (count_q != '0);
    assign pop          = out_valid & out_ready_i;
    assign free_slots_o = (PW + 1)'(`OUT_DEPTH) - count_q;
    assign frame_done_o = pop && (out_cnt_q == LAST_IDX);

    // head entry only moves on pop, so data and last hold under stall
    always_comb begin
        pix_o.valid = out_valid;
        pix_o.data  = fifo_mem[rd_ptr_q];
        pix_o.last  = out_valid && (out_cnt_q == LAST_IDX);
    end

    always_ff @(posedge clk_i) begin
        if (beat_valid_i) fifo_mem[wr_ptr_q] <= beat_data_i;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q  <= '0;
            rd_ptr_q  <= '0;
            count_q   <= '0;
            out_cnt_q <= '0;
        end else begin
            if (beat_valid_i) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop) begin
                rd_ptr_q  <= rd_ptr_q + 1'b1;
                out_cnt_q <= out_cnt_q + 1'b1;
            end
            count_q <= count_q + (PW + 1)'(beat_valid_i) - (PW + 1)'(pop);
        end
    end

endmodule

`default_nettype wire

/* hdl/pix_engine_top.sv */
`default_nettype none

`include "pix_settings.svh"

module pix_engine_top (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  pix_bus_pkg::apb_req_t apb_i,
    output pix_bus_pkg::apb_rsp_t apb_o,
    input  pix_bus_pkg::pix_in_t  pix_i,
    output logic                  in_ready_o,
    output pix_bus_pkg::pix_out_t pix_o,
    input  logic                  out_ready_i
);

    logic                    wr_en;
    logic [`FRAME_AW-1:0]    wr_addr;
    logic [`PIX_W-1:0]       wr_data;
    logic [`FRAME_AW-1:0]    rd_addr;
    logic [`PIX_W-1:0]       rd_data;
    logic                    frame_loaded;
    logic                    frame_done;
    logic                    start;
    pix_task_pkg::task_cfg_t cfg;
    pix_task_pkg::lut_wr_t   lut_wr;
    logic [2:0]              free_slots;
    logic                    beat_valid;
    logic [`PIX_W-1:0]       beat_data;

    apb_cmd_decode u_decode (
        .clk_i(clk_i), .rst_i(rst_i),
        .apb_i(apb_i), .apb_o(apb_o),
        .frame_loaded_i(frame_loaded), .frame_done_i(frame_done),
        .start_o(start), .cfg_o(cfg), .lut_wr_o(lut_wr)
    );

    block_placer u_placer (
        .clk_i(clk_i), .rst_i(rst_i),
        .pix_i(pix_i), .in_ready_o(in_ready_o),
        .wr_en_o(wr_en), .wr_addr_o(wr_addr), .wr_data_o(wr_data),
        .frame_loaded_o(frame_loaded)
    );

    frame_ram u_ram (
        .clk_i(clk_i),
        .wr_en_i(wr_en), .wr_addr_i(wr_addr), .wr_data_i(wr_data),
        .rd_addr_i(rd_addr), .rd_data_o(rd_data)
    );

    task_execute u_exec (
        .clk_i(clk_i), .rst_i(rst_i),
        .start_i(start), .cfg_i(cfg), .lut_wr_i(lut_wr),
        .rd_addr_o(rd_addr), .rd_data_i(rd_data),
        .free_slots_i(free_slots),
        .beat_valid_o(beat_valid), .beat_data_o(beat_data)
    );

    result_stream u_result (
        .clk_i(clk_i), .rst_i(rst_i),
        .beat_valid_i(beat_valid), .beat_data_i(beat_data),
        .free_slots_o(free_slots),
        .pix_o(pix_o), .out_ready_i(out_ready_i),
        .frame_done_o(frame_done)
    );

endmodule

`default_nettype wire

/* test/pix_engine_assertions.sv */
`default_nettype none

module pix_engine_assertions (
    input logic                  clk_i,
    input logic                  rst_i,
    input pix_bus_pkg::apb_req_t apb_i,
    input pix_bus_pkg::apb_rsp_t apb_o,
    input pix_bus_pkg::pix_out_t pix_o,
    input logic                  out_ready_i,
    input logic                  in_ready_o
);

    int fail_cnt = 0;

    ////////////////////////////////////////////////////////////
    // output stream
    ////////////////////////////////////////////////////////////

    hold_under_stall: assert property (@(posedge clk_i) disable iff (rst_i)
        pix_o.valid && !out_ready_i |=>
            pix_o.valid && $stable(pix_o.data) && $stable(pix_o.last))
        else begin
            $error("output beat changed while stalled");
            fail_cnt++;
        end

    last_with_valid: assert property (@(posedge clk_i) disable iff (rst_i)
        pix_o.last |-> pix_o.valid)
        else begin
            $error("last raised without valid");
            fail_cnt++;
        end

    slverr_in_access: assert property (@(posedge clk_i) disable iff (rst_i)
        apb_o.slverr |-> apb_i.sel && apb_i.enable)
        else begin
            $error("slverr outside an apb access cycle");
            fail_cnt++;
        end

    // input side closes for good after the frame
    ready_stays_low: assert property (@(posedge clk_i) disable iff (rst_i)
        !in_ready_o |=> !in_ready_o)
        else begin
            $error("in_ready rose again after the frame");
            fail_cnt++;
        end

endmodule

bind pix_engine_top pix_engine_assertions u_assert (
    .clk_i(clk_i), .rst_i(rst_i),
    .apb_i(apb_i), .apb_o(apb_o),
    .pix_o(pix_o), .out_ready_i(out_ready_i),
    .in_ready_o(in_ready_o)
);

`default_nettype wire

/* test/pix_engine_tb.sv */
`default_nettype none

`include "pix_settings.svh"

module pix_engine_tb;

    localparam int NUM_RUNS = 5;
    localparam int VEC_LEN  = `FRAME_PIX + 5 * NUM_RUNS;
    localparam int LIMIT    = 4000;      // cycles per wait loop

    logic                  clk_i;
    logic                  rst_i;
    logic                  in_ready_o;
    logic                  out_ready_i;
    pix_bus_pkg::apb_req_t apb_i;
    pix_bus_pkg::apb_rsp_t apb_o;
    pix_bus_pkg::pix_in_t  pix_i;
    pix_bus_pkg::pix_out_t pix_o;

    logic [15:0] vec_mem [VEC_LEN];
    logic [7:0]  raster [`FRAME_PIX];    // frame model, raster order
    logic [7:0]  got [`FRAME_PIX];
    logic [31:0] rng_q;
    logic [31:0] rd_word;
    logic        slverr_seen;
    int          err_cnt;
    int          tests_run;
    int          tests_failed;

    pix_engine_top u_dut (
        .clk_i(clk_i), .rst_i(rst_i),
        .apb_i(apb_i), .apb_o(apb_o),
        .pix_i(pix_i), .in_ready_o(in_ready_o),
        .pix_o(pix_o), .out_ready_i(out_ready_i)
    );

    always #2 clk_i = ~clk_i;

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // block order index to raster address
    function automatic logic [7:0] raster_index(input int n);
        int blk;
        int row;
        int col;
        blk = n / (`BLK * `BLK);
        row = (n / `BLK) % `BLK;
        col = n % `BLK;
        return 8'(((blk / (`FRAME_W / `BLK)) * `BLK + row) * `FRAME_W
                  + (blk % (`FRAME_W / `BLK)) * `BLK + col);
    endfunction

    function automatic logic [7:0] expect_pix(input logic [3:0] op, input logic [7:0] thr,
                                              input logic [7:0] p);
        case (op)
            4'd1:    return 8'd255 - p;
            4'd2:    return (p >= thr) ? 8'd255 : 8'd0;
            4'd3:    return p ^ 8'h5A;   // table written as index xor 0x5A
            default: return p;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // bus and stream tasks
    ////////////////////////////////////////////////////////////

    task automatic timeout_abort(input string what);
        $display("timeout while waiting for %s", what);
        $display("Simulation finished: FAIL");
        $finish;
    endtask

    task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] wdata);
        @(posedge clk_i);
        apb_i <= '{sel: 1'b1, enable: 1'b0, write: wr, addr: addr, wdata: wdata};
        @(posedge clk_i);
        apb_i.enable <= 1'b1;
        @(negedge clk_i);                // access cycle
        rd_word     = apb_o.rdata;
        slverr_seen = apb_o.slverr;
        @(posedge clk_i);
        apb_i <= '0;
    endtask

    task automatic load_frame();
        int n;
        int cyc;
        n = 0;
        cyc = 0;
        while (n < `FRAME_PIX && cyc < LIMIT) begin
            @(posedge clk_i);
            pix_i.valid <= 1'b1;
            pix_i.data  <= vec_mem[9'(n)][7:0];
            @(negedge clk_i);
            if (in_ready_o) n++;
            cyc++;
        end
        @(posedge clk_i);
        pix_i <= '0;
        if (n < `FRAME_PIX) timeout_abort("input stream to accept the frame");
    endtask

    task automatic collect_run(input string name, input logic [3:0] op, input logic [7:0] thr,
                               input logic stall);
        int         n;
        int         cyc;
        logic [7:0] exp;
        n = 0;
        cyc = 0;
        while (n < `FRAME_PIX && cyc < LIMIT) begin
            @(posedge clk_i);
            rng_q = xorshift32(rng_q);
            out_ready_i <= stall ? rng_q[0] : 1'b1;
            @(negedge clk_i);
            if (pix_o.valid && out_ready_i) begin
                exp = expect_pix(op, thr, raster[8'(n)]);
                got[8'(n)] = pix_o.data;
                if (pix_o.data !== exp) begin
                    $display("Fail %s pixel %0d expected %h actual %h", name, n, exp,
                             pix_o.data);
                    err_cnt++;
                end
                if (pix_o.last !== (n == `FRAME_PIX - 1)) begin
                    $display("Fail %s last at pixel %0d expected %b actual %b", name, n,
                             n == `FRAME_PIX - 1, pix_o.last);
                    err_cnt++;
                end
                n++;
            end
            cyc++;
        end
        if (n < `FRAME_PIX) timeout_abort({name, " output pixels"});
    endtask

    task automatic check_status(input string name, input logic [2:0] exp);
        apb_xfer(1'b0, `REG_STATUS, '0);
        if (rd_word !== {29'h0, exp}) begin
            $display("Fail %s status expected %h actual %h", name, {29'h0, exp}, rd_word);
            err_cnt++;
        end
    endtask

    task automatic check_slverr(input string name, input logic exp);
        if (slverr_seen !== exp) begin
            $display("Fail %s slverr expected %b actual %b", name, exp, slverr_seen);
            err_cnt++;
        end
    endtask

    task automatic check_idle(input string name);
        repeat (20) begin
            @(negedge clk_i);
            if (pix_o.valid !== 1'b0) begin
                $display("%s: output stream became active without an accepted command", name);
                err_cnt++;
            end
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests_run++;
        if (err_cnt == err_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, err_cnt - err_before);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int         n;
        int         base;
        int         err_before;
        logic [3:0] op;
        logic [7:0] thr;
        logic [7:0] probe;
        string      name;

        clk_i        = 1'b0;
        rst_i        = 1'b1;
        apb_i        = '0;
        pix_i        = '0;
        out_ready_i  = 1'b0;
        rng_q        = 32'd8;
        err_cnt      = 0;
        tests_run    = 0;
        tests_failed = 0;
        $readmemh("test/pix_engine_vectors.mem", vec_mem);
        for (n = 0; n < `FRAME_PIX; n++) begin
            raster[raster_index(n)] = vec_mem[9'(n)][7:0];
        end

        repeat (10) @(posedge clk_i);
        rst_i <= 1'b0;

        err_before = err_cnt;
        load_frame();
        n = 0;
        rd_word = '0;
        while (!rd_word[0] && n < 50) begin   // poll frame_loaded
            apb_xfer(1'b0, `REG_STATUS, '0);
            n++;
        end
        if (!rd_word[0]) timeout_abort("frame_loaded in status");
        check_status("frame_load", 3'b001);
        if (in_ready_o !== 1'b0) begin
            $display("Fail frame_load in_ready expected 0 actual %b", in_ready_o);
            err_cnt++;
        end
        finish_test("frame_load", err_before);

        for (n = 0; n < `LUT_DEPTH; n++) begin
            apb_xfer(1'b1, `REG_LUT, {16'h0, 8'(n), 8'(n) ^ 8'h5A});
        end

        for (int r = 0; r < NUM_RUNS; r++) begin
            base       = `FRAME_PIX + 5 * r;
            op         = vec_mem[9'(base + 1)][7:4];
            thr        = vec_mem[9'(base + 2)][7:0];
            probe      = vec_mem[9'(base + 3)][7:0];
            name       = $sformatf("run%0d_task%0d", vec_mem[9'(base)], op);
            err_before = err_cnt;
            apb_xfer(1'b1, `REG_PARAM, {24'h0, thr});
            apb_xfer(1'b1, `REG_CMD, {16'h0, vec_mem[9'(base + 1)]});
            check_slverr(name, 1'b0);
            collect_run(name, op, thr, op != 4'd0);   // copy runs without stalls
            if (got[probe] !== vec_mem[9'(base + 4)][7:0]) begin
                $display("Fail %s probe %h expected %h actual %h", name, probe,
                         vec_mem[9'(base + 4)][7:0], got[probe]);
                err_cnt++;
            end
            check_status(name, 3'b101);
            finish_test(name, err_before);
        end

        err_before = err_cnt;
        apb_xfer(1'b1, `REG_CMD, 32'h0000_B010);   // wrong tag
        check_slverr("bad_cmd", 1'b1);
        apb_xfer(1'b1, `REG_CMD, 32'h0000_A050);   // task 5
        check_slverr("bad_cmd", 1'b1);
        check_idle("bad_cmd");
        check_status("bad_cmd", 3'b101);
        finish_test("bad_cmd", err_before);

        // hold the output so the run stays busy
        err_before = err_cnt;
        @(posedge clk_i);
        out_ready_i <= 1'b0;
        apb_xfer(1'b1, `REG_CMD, 32'h0000_A010);
        check_slverr("busy_write", 1'b0);
        apb_xfer(1'b1, `REG_CMD, 32'h0000_A000);
        check_slverr("busy_write", 1'b1);
        collect_run("busy_write", 4'd1, 8'h00, 1'b1);
        check_status("busy_write", 3'b101);
        check_idle("busy_write");
        finish_test("busy_write", err_before);

        $display("tests run %0d, tests failed %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, err_cnt, u_dut.u_assert.fail_cnt);
        if (err_cnt == 0 && u_dut.u_assert.fail_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* test/pix_engine_vectors.mem */
// lines 1-16: frame pixels in 8x8 block order, 16 per line
// then one run per line: test number, command word, threshold, probe raster index, expected
3C 3D 3E 3F 38 39 3A 3B 34 35 36 37 30 31 32 33
2C 2D 2E 2F 28 29 2A 2B 24 25 26 27 20 21 22 23
1C 1D 1E 1F 18 19 1A 1B 14 15 16 17 10 11 12 13
0C 0D 0E 0F 08 09 0A 0B 04 05 06 07 00 01 02 03
7C 7D 7E 7F 78 79 7A 7B 74 75 76 77 70 71 72 73
6C 6D 6E 6F 68 69 6A 6B 64 65 66 67 60 61 62 63
5C 5D 5E 5F 58 59 5A 5B 54 55 56 57 50 51 52 53
4C 4D 4E 4F 48 49 4A 4B 44 45 46 47 40 41 42 43
BC BD BE BF B8 B9 BA BB B4 B5 B6 B7 B0 B1 B2 B3
AC AD AE AF A8 A9 AA AB A4 A5 A6 A7 A0 A1 A2 A3
9C 9D 9E 9F 98 99 9A 9B 94 95 96 97 90 91 92 93
8C 8D 8E 8F 88 89 8A 8B 84 85 86 87 80 81 82 83
FC FD FE FF F8 F9 FA FB F4 F5 F6 F7 F0 F1 F2 F3
EC ED EE EF E8 E9 EA EB E4 E5 E6 E7 E0 E1 E2 E3
DC DD DE DF D8 D9 DA DB D4 D5 D6 D7 D0 D1 D2 D3
CC CD CE CF C8 C9 CA CB C4 C5 C6 C7 C0 C1 C2 C3
// runs: copy, invert, threshold 0x80, threshold at the probe level, lookup
1 A000 00 9B F7
2 A010 00 27 D4
3 A020 80 5E 00
4 A020 52 5E FF
5 A030 00 F0 DE

/* files.f */
+incdir+hdl
hdl/pix_bus_pkg.sv
hdl/pix_task_pkg.sv
hdl/apb_cmd_decode.sv
hdl/block_placer.sv
hdl/frame_ram.sv
hdl/task_execute.sv
hdl/result_stream.sv
hdl/pix_engine_top.sv
test/pix_engine_assertions.sv
test/pix_engine_tb.sv

/* Makefile */
TOP = pix_engine_tb

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f files.f -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	@! grep -q "Simulation finished: FAIL" sim.log
	@grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
